//--- verilog/projection_macros.svh
`ifndef PROJECTION_MACROS_SVH
`define PROJECTION_MACROS_SVH

// input coordinate widths
`define P_WIDTH    16  // vertex coordinate, signed integer
`define C_WIDTH    18  // camera position, signed integer
`define V_WIDTH    16  // camera vector component, Q2.14
`define FRAC_BITS  14  // fraction bits of the camera vectors

// internal datapath widths
`define DIFF_WIDTH 19  // d = P - C
`define DOT_WIDTH  23  // dot product after the fraction shift
`define FOCAL_BITS 8   // numerator scale, focal length 256
`define DIV_WIDTH  32  // divider operands and quotient

// viewport, centred on the optical axis
`define VW_HALF    160
`define VH_HALF    120

// output point widths
`define SX_WIDTH   9
`define SY_WIDTH   8
`define Z_WIDTH    16

`endif

//--- verilog/projection_pkg.sv
`include "projection_macros.svh"

package projection_pkg;

  // camera position, integer units
  typedef struct packed {
    logic signed [`C_WIDTH-1:0] x;
    logic signed [`C_WIDTH-1:0] y;
    logic signed [`C_WIDTH-1:0] z;
  } vec3_c_t;

  typedef struct packed {
    logic signed [`P_WIDTH-1:0] x;  // vertex in world space
    logic signed [`P_WIDTH-1:0] y;
    logic signed [`P_WIDTH-1:0] z;
  } vec3_p_t;

  typedef struct packed {
    logic signed [`V_WIDTH-1:0] x;  // unit vector component, Q2.14
    logic signed [`V_WIDTH-1:0] y;
    logic signed [`V_WIDTH-1:0] z;
  } vec3_v_t;

  typedef struct packed {
    vec3_c_t pos;  // camera centre C
    vec3_v_t u;    // screen right
    vec3_v_t v;    // screen up
    vec3_v_t n;    // view direction
  } camera_t;

  typedef struct packed {
    logic [`SX_WIDTH-1:0] x;  // 0 at left edge
    logic [`SY_WIDTH-1:0] y;  // 0 at top edge
    logic [`Z_WIDTH-1:0]  z;  // depth along n
  } screen_pt_t;

  // one address per scalar camera register
  typedef enum logic [3:0] {
    POS_X = 4'd0, POS_Y = 4'd1, POS_Z = 4'd2,
    U_X   = 4'd3, U_Y   = 4'd4, U_Z   = 4'd5,
    V_X   = 4'd6, V_Y   = 4'd7, V_Z   = 4'd8,
    N_X   = 4'd9, N_Y   = 4'd10, N_Z  = 4'd11
  } cam_field_e;

endpackage

//--- verilog/camera_regs.sv
`timescale 1ns/1ps
`include "projection_macros.svh"

module camera_regs (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic                       cfg_we,     // single cycle write strobe
  input  projection_pkg::cam_field_e cfg_field,  // which scalar to write
  input  logic [`C_WIDTH-1:0]        cfg_data,   // sign extended by the host
  output projection_pkg::camera_t    camera
);

  // 1.0 in Q2.14
  localparam logic [`V_WIDTH-1:0] V_ONE = `V_WIDTH'(1) << `FRAC_BITS;

  logic [`V_WIDTH-1:0] vec_data;  // vector fields keep the low bits only

  assign vec_data = cfg_data[`V_WIDTH-1:0];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      // identity camera at the origin looking down +z
      camera.pos <= '0;
      camera.u   <= '{x: V_ONE, y: '0, z: '0};
      camera.v   <= '{x: '0, y: V_ONE, z: '0};
      camera.n   <= '{x: '0, y: '0, z: V_ONE};
    end else if (cfg_we) begin
      case (cfg_field)
        projection_pkg::POS_X: camera.pos.x <= cfg_data;
        projection_pkg::POS_Y: camera.pos.y <= cfg_data;
        projection_pkg::POS_Z: camera.pos.z <= cfg_data;
        projection_pkg::U_X:   camera.u.x   <= vec_data;
        projection_pkg::U_Y:   camera.u.y   <= vec_data;
        projection_pkg::U_Z:   camera.u.z   <= vec_data;
        projection_pkg::V_X:   camera.v.x   <= vec_data;
        projection_pkg::V_Y:   camera.v.y   <= vec_data;
        projection_pkg::V_Z:   camera.v.z   <= vec_data;
        projection_pkg::N_X:   camera.n.x   <= vec_data;
        projection_pkg::N_Y:   camera.n.y   <= vec_data;
        projection_pkg::N_Z:   camera.n.z   <= vec_data;
        default: ;  // unused codes 12..15 are ignored
      endcase
    end
  end

endmodule

//--- verilog/fixed_dot3.sv
`timescale 1ns/1ps
`include "projection_macros.svh"

// d . b with b in fixed point, integer result
module fixed_dot3 #(
  parameter int FRAC = `FRAC_BITS  // fraction bits carried by b
) (
  input  logic                                clk_in,
  input  logic                                rst_in,
  input  logic signed [2:0][`DIFF_WIDTH-1:0] a,    // [2]=z [1]=y [0]=x
  input  projection_pkg::vec3_v_t             b,
  output logic signed [`DOT_WIDTH-1:0]        dot
);

  localparam int PROD_W = `DIFF_WIDTH + `V_WIDTH;  // full product
  localparam int SUM_W  = PROD_W + 2;              // room for three terms

  logic signed [PROD_W-1:0] prod_x, prod_y, prod_z;  // stage one
  logic signed [SUM_W-1:0]  sum;
  logic signed [SUM_W-1:0]  sum_shift;

  // a[i] alone reads back unsigned, so re-sign each element
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      prod_x <= '0;
      prod_y <= '0;
      prod_z <= '0;
    end else begin
      prod_x <= $signed(a[0]) * b.x;
      prod_y <= $signed(a[1]) * b.y;
      prod_z <= $signed(a[2]) * b.z;
    end
  end

  always_comb begin
    sum       = prod_x + prod_y + prod_z;  // sign extended to SUM_W
    sum_shift = sum >>> FRAC;              // arithmetic, floors
  end

  // stage two, drop the fraction
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      dot <= '0;
    end else begin
      dot <= sum_shift[`DOT_WIDTH-1:0];  // top bits are sign copies
    end
  end

endmodule

//--- verilog/fixed_div.sv
`timescale 1ns/1ps

module fixed_div #(
  parameter int WIDTH = 32
) (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    start,     // ignored while busy
  input  logic signed [WIDTH-1:0] dividend,
  input  logic signed [WIDTH-1:0] divisor,   // must be positive
  output logic                    done,      // one cycle pulse
  output logic                    valid,     // low when divisor was rejected
  output logic signed [WIDTH-1:0] quotient,  // truncated toward zero
  output logic                    busy
);

  localparam int CNT_W = $clog2(WIDTH);

  logic [CNT_W-1:0] count;
  logic [WIDTH-1:0] rem;       // partial remainder, always below dvsr
  logic [WIDTH-1:0] quo;       // dividend shifts out, quotient shifts in
  logic [WIDTH-1:0] dvsr;
  logic             neg;       // result sign, taken from the dividend
  logic             bad_divisor;
  logic [WIDTH:0]   shifted;
  logic [WIDTH:0]   trial;
  logic             fits;
  logic [WIDTH-1:0] quo_next;
  logic             last;

  assign bad_divisor = divisor[WIDTH-1] || (divisor == '0);  // at or behind camera
  assign last        = (count == CNT_W'(WIDTH - 1));

  always_comb begin
    shifted  = {rem, quo[WIDTH-1]};     // bring down next dividend bit
    trial    = shifted - {1'b0, dvsr};
    fits     = !trial[WIDTH];           // no borrow, subtract sticks
    quo_next = {quo[WIDTH-2:0], fits};
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      valid <= 1'b0;
      count <= '0;
    end else begin
      done <= 1'b0;
      if (busy) begin
        // one quotient bit per cycle
        rem   <= fits ? trial[WIDTH-1:0] : shifted[WIDTH-1:0];
        quo   <= quo_next;
        count <= count + 1'b1;
        if (last) begin
          busy     <= 1'b0;
          done     <= 1'b1;
          valid    <= 1'b1;
          quotient <= neg ? $signed(~quo_next + 1'b1) : $signed(quo_next);
        end
      end else if (start) begin
        if (bad_divisor) begin
          done  <= 1'b1;  // reject next cycle
          valid <= 1'b0;
        end else begin
          busy  <= 1'b1;
          count <= '0;
          rem   <= '0;
          dvsr  <= divisor;
          neg   <= dividend[WIDTH-1];
          // magnitude, -2^(WIDTH-1) still fits as unsigned
          quo   <= dividend[WIDTH-1] ? (~dividend + 1'b1) : dividend;
        end
      end
    end
  end

endmodule

//--- verilog/vertex_projector.sv
`timescale 1ns/1ps
`include "projection_macros.svh"

module vertex_projector (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  projection_pkg::camera_t    camera,
  input  projection_pkg::vec3_p_t    vertex,
  input  logic                       valid_in,
  input  logic                       ready_in,
  output logic                       ready_out,
  output logic                       valid_out,
  output logic                       short_circuit,  // vertex dropped
  output projection_pkg::screen_pt_t point
);

  localparam int NUM_PAD = `DIV_WIDTH - `DOT_WIDTH - `FOCAL_BITS;  // dividend sign bits
  localparam int DEN_PAD = `DIV_WIDTH - `DOT_WIDTH;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,  // waiting for a vertex
    COMPUTE = 2'd1,  // dot products and divides running
    HOLD    = 2'd2   // point ready, waiting on the sink
  } state_t;

  state_t state;

  logic signed [2:0][`DIFF_WIDTH-1:0] d;  // P - C, [2]=z
  logic [2:0]                  launch;     // one hot, marks dot result arrival
  logic signed [`DOT_WIDTH-1:0] dot_u, dot_v, dot_n;
  logic signed [`DIV_WIDTH-1:0] num_x, num_y, den;
  logic                        start_x, start_y;
  logic                        done_x, done_y, valid_x, valid_y, busy_x, busy_y;
  logic signed [`DIV_WIDTH-1:0] quot_x, quot_y;
  logic signed [`DIV_WIDTH-1:0] qx, qy;    // captured quotients
  logic                        x_got, y_got;
  logic [`Z_WIDTH-1:0]         z_q;
  logic signed [`DIV_WIDTH-1:0] scr_x, scr_y;
  logic                        accept, div_fail, in_bounds;

  assign accept = (state == IDLE) && valid_in && ready_out;

  // focal scale on the numerators, plain sign extension on the depth
  assign num_x = {{NUM_PAD{dot_u[`DOT_WIDTH-1]}}, dot_u, {`FOCAL_BITS{1'b0}}};
  assign num_y = {{NUM_PAD{dot_v[`DOT_WIDTH-1]}}, dot_v, {`FOCAL_BITS{1'b0}}};
  assign den   = {{DEN_PAD{dot_n[`DOT_WIDTH-1]}}, dot_n};

  assign start_x = launch[2] && !busy_x;  // 3 cycles after accept
  assign start_y = launch[2] && !busy_y;

  // a rejected divide means n dot <= 0
  assign div_fail = (done_x && !valid_x && !x_got) || (done_y && !valid_y && !y_got);

  assign in_bounds = (qx > -`VW_HALF) && (qx < `VW_HALF) &&
                     (qy > -`VH_HALF) && (qy < `VH_HALF);
  assign scr_x = qx + `VW_HALF;   // shift origin to left edge
  assign scr_y = `VH_HALF - qy;   // screen y grows downward

  assign valid_out = (state == HOLD) && ready_in;  // only while the sink can take it

  fixed_dot3 #(.FRAC(`FRAC_BITS)) dp_u (.clk_in, .rst_in, .a(d), .b(camera.u), .dot(dot_u));
  fixed_dot3 #(.FRAC(`FRAC_BITS)) dp_v (.clk_in, .rst_in, .a(d), .b(camera.v), .dot(dot_v));
  fixed_dot3 #(.FRAC(`FRAC_BITS)) dp_n (.clk_in, .rst_in, .a(d), .b(camera.n), .dot(dot_n));

  fixed_div #(.WIDTH(`DIV_WIDTH)) div_x (
    .clk_in, .rst_in, .start(start_x), .dividend(num_x), .divisor(den),
    .done(done_x), .valid(valid_x), .quotient(quot_x), .busy(busy_x)
  );

  fixed_div #(.WIDTH(`DIV_WIDTH)) div_y (
    .clk_in, .rst_in, .start(start_y), .dividend(num_y), .divisor(den),
    .done(done_y), .valid(valid_y), .quotient(quot_y), .busy(busy_y)
  );

  // payload registers
  always_ff @(posedge clk_in) begin
    if (accept) begin
      d[0] <= vertex.x - camera.pos.x;
      d[1] <= vertex.y - camera.pos.y;
      d[2] <= vertex.z - camera.pos.z;
    end
    if (launch[2]) z_q <= dot_n[`Z_WIDTH-1:0];  // depth travels beside the divides
    if (done_x && valid_x && !x_got) qx <= quot_x;
    if (done_y && valid_y && !y_got) qy <= quot_y;
    if (state == COMPUTE && x_got && y_got && !div_fail && in_bounds) begin
      point.x <= scr_x[`SX_WIDTH-1:0];
      point.y <= scr_y[`SY_WIDTH-1:0];
      point.z <= z_q;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state         <= IDLE;
      ready_out     <= 1'b1;
      short_circuit <= 1'b0;
      launch        <= '0;
      x_got         <= 1'b0;
      y_got         <= 1'b0;
    end else begin
      short_circuit <= 1'b0;  // pulse only
      launch        <= {launch[1:0], 1'b0};
      case (state)
        IDLE: begin
          if (accept) begin
            launch    <= 3'b001;
            x_got     <= 1'b0;
            y_got     <= 1'b0;
            ready_out <= 1'b0;  // one vertex in flight at a time
            state     <= COMPUTE;
          end else begin
            ready_out <= 1'b1;
          end
        end
        COMPUTE: begin
          if (done_x && valid_x && !x_got) x_got <= 1'b1;  // capture once
          if (done_y && valid_y && !y_got) y_got <= 1'b1;
          if (div_fail || (x_got && y_got && !in_bounds)) begin
            short_circuit <= 1'b1;
            ready_out     <= 1'b1;  // free again with the pulse
            state         <= IDLE;
          end else if (x_got && y_got) begin
            state <= HOLD;
          end
        end
        HOLD: begin
          if (ready_in) begin
            ready_out <= 1'b1;  // high the cycle after valid_out
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- verilog/projection_top.sv
`timescale 1ns/1ps
`include "projection_macros.svh"

module projection_top (
  input  logic                       clk_in,
  input  logic                       rst_in,
  // host camera writes
  input  logic                       cfg_we,
  input  projection_pkg::cam_field_e cfg_field,
  input  logic [`C_WIDTH-1:0]        cfg_data,
  // vertex stream in
  input  projection_pkg::vec3_p_t    vertex,
  input  logic                       valid_in,
  output logic                       ready_out,
  // screen points out
  input  logic                       ready_in,
  output logic                       valid_out,
  output logic                       short_circuit,
  output projection_pkg::screen_pt_t point
);

  projection_pkg::camera_t camera;  // current camera, one cycle behind cfg_we

  camera_regs u_cam (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .cfg_we    (cfg_we),
    .cfg_field (cfg_field),
    .cfg_data  (cfg_data),
    .camera    (camera)
  );

  vertex_projector u_proj (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .camera        (camera),
    .vertex        (vertex),
    .valid_in      (valid_in),
    .ready_in      (ready_in),
    .ready_out     (ready_out),
    .valid_out     (valid_out),
    .short_circuit (short_circuit),
    .point         (point)
  );

endmodule

//--- verification/projection_assert.sv
`timescale 1ns/1ps

// handshake rules of the projection top level
module projection_assert (
  input logic clk_in,
  input logic rst_in,
  input logic cfg_we,
  input logic valid_in,
  input logic ready_out,
  input logic valid_out,
  input logic short_circuit
);

  // a result is either delivered or dropped
  result_exclusive: assert property (@(posedge clk_in) disable iff (rst_in)
    !(valid_out && short_circuit))
    else $error("valid_out and short_circuit high in the same cycle");

  // one delivered point per result
  sink_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
    valid_out |=> !valid_out)
    else $error("valid_out stayed high for more than one cycle");

  // acceptance closes the input side
  accept_drops_ready: assert property (@(posedge clk_in) disable iff (rst_in)
    valid_in && ready_out |=> !ready_out)
    else $error("ready_out still high the cycle after acceptance");

  // stays closed until the vertex leaves
  busy_while_in_flight: assert property (@(posedge clk_in) disable iff (rst_in)
    !ready_out && !valid_out |=> !ready_out || short_circuit)
    else $error("ready_out rose while a vertex was still in flight");

  cfg_only_when_idle: assert property (@(posedge clk_in) disable iff (rst_in)
    cfg_we |-> ready_out)
    else $error("camera write arrived while ready_out was low");

endmodule

bind projection_top projection_assert u_assert (
  .clk_in        (clk_in),
  .rst_in        (rst_in),
  .cfg_we        (cfg_we),
  .valid_in      (valid_in),
  .ready_out     (ready_out),
  .valid_out     (valid_out),
  .short_circuit (short_circuit)
);

//--- verification/projection_tb.sv
`timescale 1ns/1ps
`include "projection_macros.svh"

module projection_tb;

  typedef struct packed {
    logic is_vertex;     // V record, else W
    logic expect_point;  // P, else S
    int   line_no;       // position in the trace file
    int   a;             // field code or px
    int   b;             // data or py
    int   c;             // pz
    int   ex;
    int   ey;
    int   ez;
  } trace_rec_t;

  logic                       clk_in;
  logic                       rst_in;
  logic                       cfg_we;
  projection_pkg::cam_field_e cfg_field;
  logic [`C_WIDTH-1:0]        cfg_data;
  projection_pkg::vec3_p_t    vertex;
  logic                       valid_in;
  logic                       ready_in;
  logic                       ready_out;
  logic                       valid_out;
  logic                       short_circuit;
  projection_pkg::screen_pt_t point;

  trace_rec_t  recs[$];
  int          errors = 0;
  int          checks = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;  // set once the trace is loaded
  int          valid_seen = 0;
  int          short_seen = 0;
  string       cur_test = "startup";
  logic [31:0] lcg_state;

  projection_top u_dut (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .cfg_we        (cfg_we),
    .cfg_field     (cfg_field),
    .cfg_data      (cfg_data),
    .vertex        (vertex),
    .valid_in      (valid_in),
    .ready_out     (ready_out),
    .ready_in      (ready_in),
    .valid_out     (valid_out),
    .short_circuit (short_circuit),
    .point         (point)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;  // numerical recipes constants
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    checks++;
    assert (expected == actual)
      else begin
        $display("FAILED %s: %s expected %0d, actual %0d", cur_test, what, expected, actual);
        errors++;
      end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond)
      else begin
        $display("%s: %s", cur_test, msg);
        errors++;
      end
  endtask

  task automatic print_summary();
    $display("checks %0d, errors %0d", checks, errors);
  endtask

  task automatic load_trace();
    int         fd;
    int         code;
    int         line_no;
    logic [7:0] kind;
    string      line;
    trace_rec_t rec;
    line_no = 0;
    fd = $fopen("verification/projection_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file verification/projection_trace.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      line_no++;
      rec = '0;
      rec.line_no = line_no;
      if (code != 0 && line.getc(0) == "W") begin
        if ($sscanf(line, "W %d %d", rec.a, rec.b) == 2) recs.push_back(rec);
        else begin
          $display("trace line %0d is not a valid camera write", line_no);
          errors++;
        end
      end else if (code != 0 && line.getc(0) == "V") begin
        code = $sscanf(line, "V %d %d %d %c %d %d %d",
                       rec.a, rec.b, rec.c, kind, rec.ex, rec.ey, rec.ez);
        rec.is_vertex    = 1'b1;
        rec.expect_point = (kind == "P");
        if (code == 7 && (kind == "P" || kind == "S")) recs.push_back(rec);
        else begin
          $display("trace line %0d is not a valid vertex record", line_no);
          errors++;
        end
      end  // comments and blank lines fall through
    end
    $fclose(fd);
  endtask

  task automatic write_camera(input int field, input int data);
    @(posedge clk_in);
    cfg_we    <= 1'b1;
    cfg_field <= projection_pkg::cam_field_e'(field[3:0]);
    cfg_data  <= `C_WIDTH'(data);
    @(posedge clk_in);
    cfg_we <= 1'b0;  // visible on camera from here
    @(negedge clk_in);
  endtask

  task automatic send_vertex(input trace_rec_t rec);
    @(posedge clk_in);
    vertex.x <= `P_WIDTH'(rec.a);
    vertex.y <= `P_WIDTH'(rec.b);
    vertex.z <= `P_WIDTH'(rec.c);
    valid_in <= 1'b1;
    @(negedge clk_in);
    while (!ready_out) @(negedge clk_in);
    @(posedge clk_in);
    valid_in <= 1'b0;  // taken on this edge
    @(negedge clk_in);
    check_true(!ready_out, "ready_out stayed high after the vertex was accepted");
  endtask

  task automatic wait_for_result(input trace_rec_t rec);
    logic got;
    got = 1'b0;
    while (!got) begin  // watchdog ends a hang here
      @(negedge clk_in);
      got = valid_out || short_circuit;
    end
    check_value("valid_out", int'(rec.expect_point), int'(valid_out));
    check_value("short_circuit", int'(!rec.expect_point), int'(short_circuit));
    if (valid_out) begin
      if (rec.expect_point) begin
        check_value("point.x", rec.ex, int'(point.x));
        check_value("point.y", rec.ey, int'(point.y));
        check_value("point.z", rec.ez, int'(point.z));
      end
      @(negedge clk_in);
      check_true(ready_out, "ready_out did not return the cycle after valid_out");
    end else begin
      check_true(ready_out, "ready_out did not return together with short_circuit");
    end
  endtask

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;  // 100 ns period
  end

  // sink back-pressure, low for 0 to 7 cycles at a time
  initial begin : back_pressure
    int low_len;
    int high_len;
    ready_in  = 1'b1;
    lcg_state = 32'hd026;
    wait (rst_in == 1'b0);
    forever begin
      lcg_state = lcg_next(lcg_state);
      low_len   = int'(lcg_state[18:16]);
      lcg_state = lcg_next(lcg_state);
      high_len  = 1 + int'(lcg_state[17:16]);
      repeat (low_len) begin
        @(posedge clk_in);
        ready_in <= 1'b0;
      end
      repeat (high_len) begin
        @(posedge clk_in);
        ready_in <= 1'b1;
      end
    end
  end

  always @(negedge clk_in) begin
    if (rst_in == 1'b0) begin
      if (valid_out) valid_seen++;  // one cycle per delivered point
      if (short_circuit) short_seen++;
    end
  end

  initial begin : watchdog
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk_in);
      cycle_count++;
    end
    errors++;
    $display("timeout: %s got no response within %0d cycles", cur_test, cycle_limit);
    print_summary();
    $display("test failed");
    $finish;
  end

  initial begin : main
    int exp_points;
    int exp_shorts;
    exp_points = 0;
    exp_shorts = 0;
    rst_in    = 1'b1;
    cfg_we    = 1'b0;
    cfg_field = projection_pkg::POS_X;
    cfg_data  = '0;
    vertex    = '0;
    valid_in  = 1'b0;
    load_trace();
    cycle_limit = 60 * recs.size() + 16;  // 60 per record, plus reset
    repeat (8) @(posedge clk_in);
    rst_in <= 1'b0;
    @(negedge clk_in);
    cur_test = "reset state";
    check_value("ready_out", 1, int'(ready_out));
    check_value("valid_out", 0, int'(valid_out));
    check_value("short_circuit", 0, int'(short_circuit));
    foreach (recs[i]) begin
      cur_test = $sformatf("trace line %0d", recs[i].line_no);
      if (!recs[i].is_vertex) begin
        write_camera(recs[i].a, recs[i].b);
      end else begin
        if (recs[i].expect_point) exp_points++;
        else exp_shorts++;
        send_vertex(recs[i]);
        wait_for_result(recs[i]);
      end
    end
    repeat (4) @(negedge clk_in);  // catch any stray pulse
    cur_test = "end of trace";
    check_value("valid_out count", exp_points, valid_seen);
    check_value("short_circuit count", exp_shorts, short_seen);
    print_summary();
    if (errors == 0) $display("test passed");
    else $display("test failed");
    $finish;
  end

endmodule

//--- verification/projection_trace.txt
# W field data : camera write, field code 0..11 (pos xyz, u xyz, v xyz, n xyz), decimal data
# V px py pz kind ex ey ez : vertex, kind P expects point x y z, kind S expects short_circuit
V 10 20 100 P 185 69 100
V -30 -15 200 P 122 139 200
V 5 5 -50 S 0 0 0
V 5 5 0 S 0 0 0
V 100 0 100 S 0 0 0
V 0 -60 100 S 0 0 0
V 62 0 100 P 318 120 100
V 625 0 1000 S 0 0 0
W 0 10
W 1 -20
W 2 -100
V 10 20 100 P 160 69 200
W 0 -100
W 1 0
W 2 0
W 3 0
W 5 -16384
W 9 16384
W 11 0
V 100 30 -40 P 211 82 200
W 0 0
W 3 11585
W 5 -11585
W 9 11585
W 11 11585
V 100 50 300 P 32 75 282
W 3 16384
W 5 0
W 9 0
W 11 16384
V 0 0 50 P 160 120 50
V -100 80 300 P 75 52 300
V 7 -3 20 P 249 158 20
V 1 1 1000 P 160 120 1000
V 7 -3 9 S 0 0 0

//--- projection.f
+incdir+verilog
verilog/projection_pkg.sv
verilog/camera_regs.sv
verilog/fixed_dot3.sv
verilog/fixed_div.sv
verilog/vertex_projector.sv
verilog/projection_top.sv
verification/projection_assert.sv
verification/projection_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= projection_tb
FILELIST  ?= projection.f
BUILD     ?= obj_dir

SOURCES := $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD)
